// ==== hdl/bp_params.svh ====
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// Program counter width in bits.
`define BP_PC_WIDTH 16

// Bits in one local history entry.
`define BP_HISTORY_BITS 4

// Pc field that picks one of the pattern history tables.
`define BP_PHT_SEL_BITS 3
`define BP_PHT_SEL_LSB 4

// Pc field that picks one branch history entry.
`define BP_BHT_SEL_BITS 2
`define BP_BHT_SEL_LSB 2

// Table sizes derived from the index widths.
`define BP_BHT_ENTRIES (2 ** `BP_BHT_SEL_BITS)
`define BP_PHT_ENTRIES (2 ** `BP_HISTORY_BITS)
`define BP_NUM_PHTS (2 ** `BP_PHT_SEL_BITS)

`endif

// ==== hdl/bp_pkg.sv ====
`include "bp_params.svh"

package bp_pkg;

// Two-bit saturating counter states.
// The upper bit of the encoding is the predicted direction.
typedef enum logic [1:0] {
    strong_not_taken = 2'd0,
    weak_not_taken   = 2'd1,
    weak_taken       = 2'd2,
    strong_taken     = 2'd3
} counter_state_t;

// One local history, newest outcome in bit 0.
typedef logic [`BP_HISTORY_BITS-1:0] history_t;

endpackage : bp_pkg

// ==== hdl/branch_history_table.sv ====
`include "bp_params.svh"

module branch_history_table (
    /* INPUTS */
    input logic clk,
    input logic reset,
    input logic stall,

    input logic [`BP_BHT_SEL_BITS-1:0] index,

    input logic update,
    input logic update_value,

    /* OUTPUTS */
    output bp_pkg::history_t history
);

bp_pkg::history_t entries [`BP_BHT_ENTRIES];
bp_pkg::history_t shifted;
logic write_enable;

assign history = entries[index];  // Read path is purely combinational.

assign write_enable = update && !stall;
assign shifted = {entries[index][`BP_HISTORY_BITS-2:0], update_value};  // Oldest bit drops.

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
            entries[i] <= '0;
        end
    end else if (write_enable) begin
        entries[index] <= shifted;
    end
end

endmodule : branch_history_table

// ==== hdl/branch_predictor.sv ====
`include "bp_params.svh"

module branch_predictor (
    /* INPUTS */
    input logic clk,
    input logic reset,
    input logic stall,

    input logic [`BP_PC_WIDTH-1:0] pc,

    input logic update,
    input logic update_value,

    /* OUTPUTS */
    output logic prediction
);

logic [`BP_BHT_SEL_BITS-1:0] bht_index;
logic [`BP_PHT_SEL_BITS-1:0] pht_select;
bp_pkg::history_t history;

assign bht_index  = pc[`BP_BHT_SEL_LSB +: `BP_BHT_SEL_BITS];
assign pht_select = pc[`BP_PHT_SEL_LSB +: `BP_PHT_SEL_BITS];

branch_history_table _branch_history_table (
    /* INPUTS */
    .clk,
    .reset,
    .stall,
    .index(bht_index),
    .update,
    .update_value,

    /* OUTPUTS */
    .history
);

// History from the first level addresses the counters in the second.
pattern_table_bank _pattern_table_bank (
    /* INPUTS */
    .clk,
    .reset,
    .stall,
    .select(pht_select),
    .history,
    .update,
    .update_value,

    /* OUTPUTS */
    .prediction
);

endmodule : branch_predictor

// ==== hdl/pattern_history_table.sv ====
`include "bp_params.svh"

module pattern_history_table (
    /* INPUTS */
    input logic clk,
    input logic reset,
    input logic stall,

    input bp_pkg::history_t index,

    input logic update,
    input logic update_value,

    /* OUTPUTS */
    output logic prediction
);

bp_pkg::counter_state_t counters [`BP_PHT_ENTRIES];
bp_pkg::counter_state_t current;
bp_pkg::counter_state_t trained;
logic write_enable;

// One saturating step toward the observed outcome.
function automatic bp_pkg::counter_state_t step(
    input bp_pkg::counter_state_t state,
    input logic                   taken
);
    bp_pkg::counter_state_t next;
    next = state;
    case (state)
        bp_pkg::strong_not_taken: begin
            if (taken) next = bp_pkg::weak_not_taken;
        end
        bp_pkg::weak_not_taken: begin
            next = taken ? bp_pkg::weak_taken : bp_pkg::strong_not_taken;
        end
        bp_pkg::weak_taken: begin
            next = taken ? bp_pkg::strong_taken : bp_pkg::weak_not_taken;
        end
        bp_pkg::strong_taken: begin
            if (!taken) next = bp_pkg::weak_taken;
        end
        default: next = bp_pkg::weak_not_taken;
    endcase
    return next;
endfunction

assign current = counters[index];
assign prediction = current[1];  // Upper bit is the direction.

assign write_enable = update && !stall;
assign trained = step(current, update_value);

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
            counters[i] <= bp_pkg::weak_not_taken;
        end
    end else if (write_enable) begin
        counters[index] <= trained;  // Indexed by the pre-edge history.
    end
end

endmodule : pattern_history_table

// ==== hdl/pattern_table_bank.sv ====
`include "bp_params.svh"

module pattern_table_bank (
    /* INPUTS */
    input logic clk,
    input logic reset,
    input logic stall,

    input logic [`BP_PHT_SEL_BITS-1:0] select,
    input bp_pkg::history_t history,

    input logic update,
    input logic update_value,

    /* OUTPUTS */
    output logic prediction
);

logic [`BP_NUM_PHTS-1:0] table_update;
logic [`BP_NUM_PHTS-1:0] table_prediction;

// Only the selected table sees the update strobe.
always_comb begin
    table_update = '0;
    table_update[select] = update;
end

for (genvar t = 0; t < `BP_NUM_PHTS; t++) begin : g_table
    pattern_history_table _pattern_history_table (
        /* INPUTS */
        .clk,
        .reset,
        .stall,
        .index(history),
        .update(table_update[t]),
        .update_value,

        /* OUTPUTS */
        .prediction(table_prediction[t])
    );
end

assign prediction = table_prediction[select];  // Same table that trains.

endmodule : pattern_table_bank

// ==== project.f ====
+incdir+hdl
+incdir+testbench
hdl/bp_pkg.sv
hdl/branch_history_table.sv
hdl/pattern_history_table.sv
hdl/pattern_table_bank.sv
hdl/branch_predictor.sv
testbench/branch_predictor_tb.sv

// ==== testbench/bp_reference.svh ====
`ifndef BP_REFERENCE_SVH
`define BP_REFERENCE_SVH

`include "bp_params.svh"

// Shadow copy of both predictor levels.
bp_pkg::history_t       model_history  [`BP_BHT_ENTRIES];
bp_pkg::counter_state_t model_counters [`BP_NUM_PHTS][`BP_PHT_ENTRIES];

// History entry addressed by a pc.
function automatic int history_slot(input logic [`BP_PC_WIDTH-1:0] p);
    return int'(p[`BP_BHT_SEL_LSB +: `BP_BHT_SEL_BITS]);
endfunction

// Pattern table addressed by a pc.
function automatic int table_slot(input logic [`BP_PC_WIDTH-1:0] p);
    return int'(p[`BP_PHT_SEL_LSB +: `BP_PHT_SEL_BITS]);
endfunction

task automatic model_reset();
    for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
        model_history[i] = '0;
    end
    for (int t = 0; t < `BP_NUM_PHTS; t++) begin
        for (int e = 0; e < `BP_PHT_ENTRIES; e++) begin
            model_counters[t][e] = bp_pkg::weak_not_taken;
        end
    end
endtask

// One rising edge, using the values present before it.
task automatic model_edge(
    input logic                    rst,
    input logic                    stl,
    input logic [`BP_PC_WIDTH-1:0] p,
    input logic                    upd,
    input logic                    taken
);
    int slot;
    int bank;
    int level;
    bp_pkg::history_t old_history;
    if (rst) begin
        model_reset();
    end else if (upd && !stl) begin
        slot = history_slot(p);
        bank = table_slot(p);
        old_history = model_history[slot];
        level = int'(model_counters[bank][old_history]);
        if (taken && level < 3) begin
            level = level + 1;  // Saturates at strong_taken.
        end else if (!taken && level > 0) begin
            level = level - 1;
        end
        model_counters[bank][old_history] = bp_pkg::counter_state_t'(level[1:0]);
        model_history[slot] = bp_pkg::history_t'({old_history, taken});  // Newest in bit 0.
    end
endtask

// Expected direction for a pc with the current model state.
function automatic logic expected_prediction(input logic [`BP_PC_WIDTH-1:0] p);
    bp_pkg::counter_state_t state;
    state = model_counters[table_slot(p)][model_history[history_slot(p)]];
    return (state == bp_pkg::weak_taken) || (state == bp_pkg::strong_taken);
endfunction

`endif

// ==== testbench/branch_predictor_tb.sv ====
`include "bp_params.svh"

module branch_predictor_tb;

localparam int clk_period = 4;
localparam int reset_cycles = 16;
localparam int num_combos = `BP_NUM_PHTS * `BP_BHT_ENTRIES;
localparam int sweep_cycles = 2 * num_combos;
localparam int directed_cycles = 200;
localparam int random_cycles = 2000;
localparam int total_cycles = 3 * reset_cycles + 3 * sweep_cycles + directed_cycles
                              + random_cycles;
localparam int timeout_time = total_cycles * clk_period + 100 * clk_period;

logic clk = 1'b0;
logic reset;
logic stall;
logic [`BP_PC_WIDTH-1:0] pc;
logic update;
logic update_value;
logic prediction;

logic expected_value;
event compare_done;

`include "bp_reference.svh"

branch_predictor DUT (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .pc(pc),
    .update(update),
    .update_value(update_value),
    .prediction(prediction)
);

// Clock starts low with no edge at time zero.
initial begin
    forever #(clk_period / 2) clk = ~clk;
end

always @(posedge clk) begin
    model_edge(reset, stall, pc, update, update_value);
end

// Checked on every falling edge, before the stimulus moves on.
always @(negedge clk) begin
    expected_value = expected_prediction(pc);
    assert (prediction === expected_value) else begin
        $display("FAILED prediction expected 0x%0h got 0x%0h", expected_value, prediction);
        $display("SOME TESTS FAILED");
        $fatal(1, "Mismatch at pc 0x%0h, time %0t", pc, $time);
    end
    -> compare_done;
end

initial begin
    #(timeout_time);
    $display("Timeout: the tests did not finish within the expected number of cycles");
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped by the watchdog at time %0t", $time);
end

// Random pc with the two index fields forced.
function automatic logic [`BP_PC_WIDTH-1:0] compose_pc(input int table_sel, input int hist_sel);
    logic [`BP_PC_WIDTH-1:0] p;
    p = `BP_PC_WIDTH'($urandom);
    p[`BP_PHT_SEL_LSB +: `BP_PHT_SEL_BITS] = table_sel[`BP_PHT_SEL_BITS-1:0];
    p[`BP_BHT_SEL_LSB +: `BP_BHT_SEL_BITS] = hist_sel[`BP_BHT_SEL_BITS-1:0];
    return p;
endfunction

task automatic drive_cycle(
    input logic [`BP_PC_WIDTH-1:0] p,
    input logic                    upd,
    input logic                    value,
    input logic                    stl
);
    @(compare_done);
    pc = p;
    update = upd;
    update_value = value;
    stall = stl;
endtask

task automatic apply_reset(input int cycles);
    @(compare_done);
    reset = 1'b1;
    update = 1'b0;
    stall = 1'b0;
    repeat (cycles) @(compare_done);
    reset = 1'b0;
endtask

task automatic train(input logic [`BP_PC_WIDTH-1:0] p, input logic value, input int count);
    for (int i = 0; i < count; i++) begin
        drive_cycle(p, 1'b1, value, 1'b0);
    end
endtask

// Shows pc for one cycle without an update and samples the result.
task automatic read_prediction(input logic [`BP_PC_WIDTH-1:0] p, output logic value);
    drive_cycle(p, 1'b0, 1'b0, 1'b0);
    @(compare_done);
    value = prediction;
endtask

task automatic expect_prediction(input logic [`BP_PC_WIDTH-1:0] p, input logic expected);
    logic value;
    read_prediction(p, value);
    assert (value === expected) else begin
        $display("FAILED prediction expected 0x%0h got 0x%0h", expected, value);
        $display("SOME TESTS FAILED");
        $fatal(1, "Directed check failed at pc 0x%0h", p);
    end
endtask

task automatic sweep_predictions(output logic [num_combos-1:0] snap);
    logic value;
    for (int i = 0; i < num_combos; i++) begin
        read_prediction(compose_pc(i / `BP_BHT_ENTRIES, i % `BP_BHT_ENTRIES), value);
        snap[i] = value;
    end
endtask

initial begin
    logic [`BP_PC_WIDTH-1:0] pc_a;
    logic [`BP_PC_WIDTH-1:0] pc_b;
    logic [num_combos-1:0] before_stall;
    logic [num_combos-1:0] after_stall;
    logic outcome;

    void'($urandom(32'h8b22));
    reset = 1'b1;
    stall = 1'b0;
    pc = '0;
    update = 1'b0;
    update_value = 1'b0;

    repeat (reset_cycles) @(compare_done);
    reset = 1'b0;

    // Every table and history entry starts at weak_not_taken.
    for (int i = 0; i < num_combos; i++) begin
        expect_prediction(compose_pc(i / `BP_BHT_ENTRIES, i % `BP_BHT_ENTRIES), 1'b0);
    end

    // Saturating training at a fixed pc.
    pc_a = compose_pc(3, 1);
    train(pc_a, 1'b1, 6);
    expect_prediction(pc_a, 1'b1);
    train(pc_a, 1'b1, 4);
    expect_prediction(pc_a, 1'b1);
    train(pc_a, 1'b0, 3);
    expect_prediction(pc_a, 1'b0);

    // Alternating outcomes, one counter per history pattern.
    apply_reset(reset_cycles);
    pc_a = compose_pc(6, 3);
    for (int n = 0; n < 8; n++) begin
        train(pc_a, (n % 2 == 0), 1);
    end
    for (int n = 8; n < 16; n++) begin
        outcome = (n % 2 == 0);
        expect_prediction(pc_a, outcome);
        train(pc_a, outcome, 1);
    end

    // Stalled updates leave both levels untouched.
    sweep_predictions(before_stall);
    for (int i = 0; i < 40; i++) begin
        drive_cycle(`BP_PC_WIDTH'($urandom), 1'b1, 1'($urandom), 1'b1);
    end
    sweep_predictions(after_stall);
    assert (after_stall === before_stall) else begin
        $display("FAILED prediction expected 0x%0h got 0x%0h", before_stall, after_stall);
        $display("SOME TESTS FAILED");
        $fatal(1, "Predictions changed while stalled");
    end

    // Table and history isolation.
    apply_reset(reset_cycles);
    pc_a = compose_pc(1, 2);
    train(pc_a, 1'b1, 8);
    expect_prediction(pc_a, 1'b1);
    for (int t = 0; t < `BP_NUM_PHTS; t++) begin
        if (t != 1) begin
            expect_prediction(compose_pc(t, 2), 1'b0);  // Same history, untrained table.
        end
    end
    pc_b = compose_pc(1, 0);
    train(pc_b, 1'b0, 4);
    expect_prediction(pc_b, 1'b0);
    expect_prediction(pc_a, 1'b1);

    // Random traffic with occasional reset pulses.
    for (int i = 0; i < random_cycles; i++) begin
        @(compare_done);
        reset = ($urandom_range(0, 199) == 0);
        pc = `BP_PC_WIDTH'($urandom);
        update = 1'($urandom);
        update_value = 1'($urandom);
        stall = ($urandom_range(0, 3) == 0);
    end
    @(compare_done);
    reset = 1'b0;
    update = 1'b0;
    stall = 1'b0;
    @(compare_done);

    $display("ALL TESTS PASSED");
    $finish;
end

endmodule : branch_predictor_tb
